// ==== filelist.f ====
+incdir+include
src/gpu_isa_pkg.sv
src/gpu_core_pkg.sv
src/core_scheduler.sv
src/lane_completion_counter.sv
src/instruction_fetcher.sv
src/instruction_decoder.sv
src/thread_lane.sv
src/compute_core.sv
testbench/tb_mem_model.sv
testbench/tb_compute_core.sv

// ==== testbench/tb_compute_core.sv ====
// Directed testbench for the compute core; top module of the simulation, reports pass or fail
`timescale 1ns/1ps
`include "gpu_defines.svh"

module tb_compute_core;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 10;
    localparam int DRIVE_DELAY   = 1;
    localparam int KERNEL_RUNS   = 6;
    localparam int KERNEL_CYCLES = 1500;

    logic clk = 1'b0;
    logic arst_n;
    logic start;
    logic done;
    gpu_isa_pkg::word_t block_id;
    gpu_core_pkg::thread_cnt_t thread_count;
    logic prog_req;
    logic prog_ack;
    gpu_isa_pkg::pc_t prog_addr;
    gpu_isa_pkg::instr_t prog_data;
    logic [`GPU_THREADS-1:0] data_req;
    logic [`GPU_THREADS-1:0] data_ack;
    logic [`GPU_THREADS-1:0] req_seen = '0;
    gpu_core_pkg::mem_req_t [`GPU_THREADS-1:0] data_req_info;
    gpu_isa_pkg::word_t [`GPU_THREADS-1:0] data_rdata;
    logic [31:0] rng_state = 32'hd790;
    string test_name;
    int prog_len;
    int test_errors;
    int errors;
    int tests_failed;
    int checks;

    always #(CLK_PERIOD / 2) clk = ~clk;

    compute_core i_compute_core (.*);

    tb_mem_model i_mem_model (.*);

    // Lanes that raised data_req since the last clear
    always @(negedge clk) begin
        req_seen = req_seen | data_req;
    end

    // Bound for the whole run: reset plus every kernel at its worst case
    initial begin
        #((RESET_CYCLES + KERNEL_RUNS * KERNEL_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired, a kernel never completed its start/done handshake");
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // opcode, then rd or nzp, rs and rt
    function automatic gpu_isa_pkg::instr_t reg_instr(input gpu_isa_pkg::opcode_e op,
                                                     input int rd, input int rs, input int rt);
        return {op, 4'(rd), 4'(rs), 4'(rt)};
    endfunction

    // opcode, then rd or nzp, and an 8-bit immediate
    function automatic gpu_isa_pkg::instr_t imm_instr(input gpu_isa_pkg::opcode_e op,
                                                     input int hi, input int imm);
        return {op, 4'(hi), 8'(imm)};
    endfunction

    function automatic int clear_value(input int addr);
        return (addr ^ 'h3c) & 255;
    endfunction

    // Unused program words are RET, so a runaway kernel still ends
    task automatic new_program();
        for (int a = 0; a < 2**`GPU_ADDR_W; a++) begin
            i_mem_model.prog_mem[a] = imm_instr(gpu_isa_pkg::RET, 0, a);
        end
        prog_len = 0;
    endtask

    task automatic emit(input gpu_isa_pkg::instr_t word);
        i_mem_model.prog_mem[prog_len] = word;
        prog_len++;
    endtask

    task automatic clear_data();
        for (int a = 0; a < 2**`GPU_ADDR_W; a++) begin
            i_mem_model.data_mem[a] = gpu_isa_pkg::word_t'(clear_value(a));
        end
    endtask

    task automatic check_mem(input int addr, input int expected);
        int actual;
        actual = int'(i_mem_model.data_mem[addr]);
        checks++;
        assert (actual == (expected & 255)) else begin
            $display("ERROR %s: mem[%0d] expected 0x%0h actual 0x%0h",
                     test_name, addr, expected & 255, actual);
            test_errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%s failed: %s", test_name, what);
            test_errors++;
        end
    endtask

    task automatic open_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic close_test();
        if (test_errors != 0)
            tests_failed++;
        errors += test_errors;
        $display("%-14s finished with %0d errors", test_name, test_errors);
    endtask

    // Full start/done handshake, returns once done is low again
    task automatic run_kernel(input int blk, input int tcount);
        @(posedge clk);
        #DRIVE_DELAY;
        block_id     = gpu_isa_pkg::word_t'(blk);
        thread_count = gpu_core_pkg::thread_cnt_t'(tcount);
        start        = 1'b1;
        do @(negedge clk); while (done !== 1'b1);
        @(posedge clk);
        #DRIVE_DELAY;
        start = 1'b0;
        do @(negedge clk); while (done !== 1'b0);
    endtask

    // mem[tid] = tid * 3 + block_id - 1
    task automatic load_arith_program();
        new_program();
        emit(imm_instr(gpu_isa_pkg::CONST, 0, 3));
        emit(imm_instr(gpu_isa_pkg::CONST, 1, 1));
        emit(reg_instr(gpu_isa_pkg::MUL, 2, 15, 0));
        emit(reg_instr(gpu_isa_pkg::ADD, 2, 2, 13));
        emit(reg_instr(gpu_isa_pkg::SUB, 2, 2, 1));
        emit(reg_instr(gpu_isa_pkg::STR, 0, 15, 2));
        emit(imm_instr(gpu_isa_pkg::RET, 0, 0));
    endtask

    task automatic check_arith(input int blk);
        for (int t = 0; t < `GPU_THREADS; t++) begin
            check_mem(t, t * 3 + blk - 1);
        end
    endtask

    task automatic test_reset_state();
        open_test("reset_state");
        for (int c = 0; c < RESET_CYCLES + 3; c++) begin
            if (c == RESET_CYCLES) begin
                @(posedge clk);
                #DRIVE_DELAY;
                arst_n = 1'b1;
            end
            @(negedge clk);
            check_true(done === 1'b0, "done was not low");
            check_true(prog_req === 1'b0, "prog_req was not low");
            check_true(data_req === '0, "a data_req bit was not low");
        end
        close_test();
    endtask

    task automatic test_arithmetic();
        open_test("arithmetic");
        load_arith_program();
        clear_data();
        run_kernel(7, `GPU_THREADS);
        check_arith(7);
        close_test();
    endtask

    task automatic test_load_store();
        gpu_isa_pkg::word_t src [`GPU_THREADS];
        open_test("load_store");
        new_program();
        emit(imm_instr(gpu_isa_pkg::CONST, 0, 16));
        emit(imm_instr(gpu_isa_pkg::CONST, 1, 32));
        emit(imm_instr(gpu_isa_pkg::CONST, 2, 5));
        emit(reg_instr(gpu_isa_pkg::ADD, 3, 0, 15));
        emit(reg_instr(gpu_isa_pkg::LDR, 4, 3, 0));
        emit(reg_instr(gpu_isa_pkg::ADD, 4, 4, 2));
        emit(reg_instr(gpu_isa_pkg::ADD, 5, 1, 15));
        emit(reg_instr(gpu_isa_pkg::STR, 0, 5, 4));
        emit(imm_instr(gpu_isa_pkg::RET, 0, 0));
        clear_data();
        for (int t = 0; t < `GPU_THREADS; t++) begin
            rng_state = xorshift32(rng_state);
            // Lane 0 always wraps past 255
            src[t] = (t == 0) ? 8'hfd : rng_state[7:0];
            i_mem_model.data_mem[16 + t] = src[t];
        end
        run_kernel(0, `GPU_THREADS);
        for (int t = 0; t < `GPU_THREADS; t++) begin
            check_mem(32 + t, int'(src[t]) + 5);
        end
        close_test();
    endtask

    task automatic test_branch_loop();
        int count;
        int total;
        open_test("branch_loop");
        new_program();
        emit(imm_instr(gpu_isa_pkg::CONST, 0, 0));
        emit(imm_instr(gpu_isa_pkg::CONST, 1, 1));
        emit(imm_instr(gpu_isa_pkg::CONST, 2, 7));
        emit(imm_instr(gpu_isa_pkg::CONST, 3, 0));
        // Loop body at address 4, taken again while count is below 7
        emit(reg_instr(gpu_isa_pkg::ADD, 0, 0, 1));
        emit(reg_instr(gpu_isa_pkg::ADD, 3, 3, 0));
        emit(reg_instr(gpu_isa_pkg::CMP, 0, 0, 2));
        emit(imm_instr(gpu_isa_pkg::BRNZP, 4'b1000, 4));
        emit(imm_instr(gpu_isa_pkg::CONST, 4, 8));
        emit(reg_instr(gpu_isa_pkg::ADD, 4, 4, 15));
        emit(reg_instr(gpu_isa_pkg::STR, 0, 4, 0));
        emit(imm_instr(gpu_isa_pkg::CONST, 5, 12));
        emit(reg_instr(gpu_isa_pkg::ADD, 5, 5, 15));
        emit(reg_instr(gpu_isa_pkg::STR, 0, 5, 3));
        emit(imm_instr(gpu_isa_pkg::RET, 0, 0));
        clear_data();
        run_kernel(1, `GPU_THREADS);
        count = 0;
        total = 0;
        do begin
            count++;
            total += count;
        end while (count < 7);
        for (int t = 0; t < `GPU_THREADS; t++) begin
            check_mem(8 + t, count);
            check_mem(12 + t, total);
        end
        close_test();
    endtask

    task automatic test_partial_block();
        open_test("partial_block");
        new_program();
        emit(reg_instr(gpu_isa_pkg::ADD, 0, 15, 13));
        emit(reg_instr(gpu_isa_pkg::ADD, 0, 0, 14));
        emit(reg_instr(gpu_isa_pkg::STR, 0, 15, 0));
        emit(imm_instr(gpu_isa_pkg::RET, 0, 0));
        clear_data();
        req_seen = '0;
        run_kernel(20, 2);
        for (int a = 0; a < 2**`GPU_ADDR_W; a++) begin
            check_mem(a, (a < 2) ? a + 20 + 2 : clear_value(a));
        end
        for (int t = 2; t < `GPU_THREADS; t++) begin
            check_true(!req_seen[t], $sformatf("disabled lane %0d raised data_req", t));
        end
        close_test();
    endtask

    task automatic test_back_to_back();
        open_test("back_to_back");
        load_arith_program();
        clear_data();
        run_kernel(3, `GPU_THREADS);
        check_arith(3);
        clear_data();
        run_kernel(254, `GPU_THREADS);
        check_arith(254);
        check_true(i_compute_core.state == gpu_core_pkg::IDLE, "core did not return to IDLE");
        close_test();
    endtask

    initial begin
        arst_n       = 1'b0;
        start        = 1'b0;
        block_id     = '0;
        thread_count = '0;
        test_reset_state();
        test_arithmetic();
        test_load_store();
        test_branch_loop();
        test_partial_block();
        test_back_to_back();
        $display("tests 6, failed %0d, checks %0d, errors %0d", tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== testbench/tb_mem_model.sv ====
// Behavioral program and data memories for the core testbench, answering four-phase requests
`timescale 1ns/1ps
`include "gpu_defines.svh"

module tb_mem_model (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  logic                                      prog_req,
    input  gpu_isa_pkg::pc_t                          prog_addr,
    output logic                                      prog_ack,
    output gpu_isa_pkg::instr_t                       prog_data,
    input  logic [`GPU_THREADS-1:0]                   data_req,
    input  gpu_core_pkg::mem_req_t [`GPU_THREADS-1:0] data_req_info,
    output logic [`GPU_THREADS-1:0]                   data_ack,
    output gpu_isa_pkg::word_t [`GPU_THREADS-1:0]     data_rdata
);

    // Filled and inspected by the test tasks
    gpu_isa_pkg::instr_t prog_mem [2**`GPU_ADDR_W];
    gpu_isa_pkg::word_t  data_mem [2**`GPU_ADDR_W];

    logic [31:0] rng_state = 32'hd790;
    gpu_core_pkg::mem_req_t req;
    // Cycles left before the next ack, -1 while no delay is drawn
    int prog_delay = -1;
    int data_delay [`GPU_THREADS];

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic draw_delay(inout int delay);
        if (delay < 0) begin
            rng_state = xorshift32(rng_state);
            delay = int'(rng_state[1:0]);
        end
    endtask

    initial begin
        prog_ack   = 1'b0;
        prog_data  = '0;
        data_ack   = '0;
        data_rdata = '0;
        for (int i = 0; i < `GPU_THREADS; i++) begin
            data_delay[i] = -1;
        end
    end

    always @(posedge clk) begin
        #1;
        if (!arst_n) begin
            prog_ack = 1'b0;
            data_ack = '0;
        end else begin
            // A raised ack follows req down
            if (prog_ack) begin
                prog_ack = prog_req;
            end else if (prog_req) begin
                draw_delay(prog_delay);
                if (prog_delay == 0) begin
                    prog_data = prog_mem[prog_addr];
                    prog_ack  = 1'b1;
                end
                prog_delay--;
            end
            // Lanes served in index order
            for (int i = 0; i < `GPU_THREADS; i++) begin
                req = data_req_info[i];
                if (data_ack[i]) begin
                    data_ack[i] = data_req[i];
                end else if (data_req[i]) begin
                    draw_delay(data_delay[i]);
                    if (data_delay[i] == 0) begin
                        if (req.write) begin
                            data_mem[req.addr] = req.wdata;
                        end
                        data_rdata[i] = data_mem[req.addr];
                        data_ack[i]   = 1'b1;
                    end
                    data_delay[i]--;
                end
            end
        end
    end

endmodule

// ==== src/compute_core.sv ====
// Top of the compute core: shared control plus one generated lane per thread
`timescale 1ns/1ps
`include "gpu_defines.svh"

module compute_core (
    input  logic                                       clk,
    input  logic                                       arst_n,
    input  logic                                       start,
    output logic                                       done,
    input  gpu_isa_pkg::word_t                         block_id,
    input  gpu_core_pkg::thread_cnt_t                  thread_count,
    output logic                                       prog_req,
    output gpu_isa_pkg::pc_t                           prog_addr,
    input  logic                                       prog_ack,
    input  gpu_isa_pkg::instr_t                        prog_data,
    output logic [`GPU_THREADS-1:0]                    data_req,
    output gpu_core_pkg::mem_req_t [`GPU_THREADS-1:0]  data_req_info,
    input  logic [`GPU_THREADS-1:0]                    data_ack,
    input  gpu_isa_pkg::word_t [`GPU_THREADS-1:0]      data_rdata
);

    gpu_core_pkg::core_state_e state;
    gpu_isa_pkg::pc_t          pc;
    gpu_isa_pkg::pc_t          lane_next_pc [`GPU_THREADS];
    gpu_isa_pkg::instr_t       instr;
    gpu_isa_pkg::decoded_t     decoded;
    gpu_isa_pkg::word_t        blk_q;
    gpu_core_pkg::thread_cnt_t tcount_q;
    logic [`GPU_THREADS-1:0]   mem_done;
    logic                      fetch_done;
    logic                      mem_all_done;

    // Block info captured as start rises
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tcount_q <= '0;
        end else if (state == gpu_core_pkg::IDLE && start) begin
            tcount_q <= thread_count;
        end
    end

    always_ff @(posedge clk) begin
        if (state == gpu_core_pkg::IDLE && start) begin
            blk_q <= block_id;
        end
    end

    core_scheduler i_core_scheduler (.clk, .arst_n, .start, .fetch_done, .mem_all_done,
        .decoded, .next_pc(lane_next_pc[0]), .state, .pc, .done);

    lane_completion_counter i_lane_completion_counter (.clk, .arst_n, .state, .decoded,
        .thread_count(tcount_q), .mem_done, .mem_all_done);

    instruction_fetcher i_instruction_fetcher (.clk, .arst_n, .state, .pc, .prog_req,
        .prog_addr, .prog_ack, .prog_data, .instr, .fetch_done);

    instruction_decoder i_instruction_decoder (.clk, .arst_n, .state, .instr, .decoded);

    // No divergence, lane 0 picks the block's next PC
    for (genvar i = 0; i < `GPU_THREADS; i++) begin : g_lane
        thread_lane #(.LANE_ID(i)) i_thread_lane (
            .clk, .arst_n, .state, .decoded, .pc,
            .enable(gpu_core_pkg::thread_cnt_t'(i) < tcount_q),
            .block_id(blk_q), .thread_count(tcount_q),
            .data_req(data_req[i]), .data_req_info(data_req_info[i]),
            .data_ack(data_ack[i]), .data_rdata(data_rdata[i]),
            .mem_done(mem_done[i]), .next_pc(lane_next_pc[i])
        );
    end

endmodule

// ==== src/thread_lane.sv ====
// One thread's datapath: register file, ALU, NZP flags, next PC and a four-phase load-store unit
`timescale 1ns/1ps
`include "gpu_defines.svh"

module thread_lane #(
    parameter int LANE_ID = 0
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  gpu_core_pkg::core_state_e state,
    input  gpu_isa_pkg::decoded_t     decoded,
    input  gpu_isa_pkg::pc_t          pc,
    input  logic                      enable,
    input  gpu_isa_pkg::word_t        block_id,
    input  gpu_core_pkg::thread_cnt_t thread_count,
    output logic                      data_req,
    output gpu_core_pkg::mem_req_t    data_req_info,
    input  logic                      data_ack,
    input  gpu_isa_pkg::word_t        data_rdata,
    output logic                      mem_done,
    output gpu_isa_pkg::pc_t          next_pc
);

    // Top three register indices are read-only
    localparam int WR_REGS = `GPU_NUM_REGS - 3;

    typedef enum logic [1:0] {LSU_IDLE, LSU_REQ, LSU_DROP} lsu_phase_e;

    gpu_isa_pkg::word_t regs [WR_REGS];
    gpu_isa_pkg::word_t rs_q, rt_q, alu_q, load_q, alu_res, wb_val;
    logic [2:0] nzp, cmp_nzp_q;
    logic signed [`GPU_DATA_W:0] diff;
    lsu_phase_e lsu_phase;
    logic mem_op;

    function automatic gpu_isa_pkg::word_t read_reg(input gpu_isa_pkg::reg_idx_t idx);
        gpu_isa_pkg::word_t val;
        case (int'(idx))
            WR_REGS:     val = block_id;
            WR_REGS + 1: val = gpu_isa_pkg::word_t'(thread_count);
            WR_REGS + 2: val = gpu_isa_pkg::word_t'(LANE_ID);
            default:     val = regs[idx];
        endcase
        return val;
    endfunction

    assign mem_op = decoded.mem_read || decoded.mem_write;

    // Load-store handshake, one access per memory instruction
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lsu_phase <= LSU_IDLE;
        end else begin
            case (lsu_phase)
                LSU_IDLE: if (state == gpu_core_pkg::REQUEST && enable && mem_op) lsu_phase <= LSU_REQ;
                LSU_REQ:  if (data_ack) lsu_phase <= LSU_DROP;
                LSU_DROP: if (!data_ack) lsu_phase <= LSU_IDLE;
                default:  lsu_phase <= LSU_IDLE;
            endcase
        end
    end

    assign data_req = (lsu_phase == LSU_REQ);
    assign mem_done = (lsu_phase == LSU_DROP) && !data_ack;

    // CMP flags come from the signed difference, N Z P from high to low
    always_comb begin
        diff = $signed({rs_q[`GPU_DATA_W-1], rs_q}) - $signed({rt_q[`GPU_DATA_W-1], rt_q});
        case (decoded.opcode)
            gpu_isa_pkg::ADD: alu_res = rs_q + rt_q;
            gpu_isa_pkg::SUB, gpu_isa_pkg::CMP: alu_res = rs_q - rt_q;
            gpu_isa_pkg::MUL: alu_res = rs_q * rt_q;
            default: alu_res = '0;
        endcase
    end

    always_comb begin
        case (decoded.opcode)
            gpu_isa_pkg::LDR:   wb_val = load_q;
            gpu_isa_pkg::CONST: wb_val = decoded.imm;
            default:            wb_val = alu_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == gpu_core_pkg::REQUEST) begin
            rs_q                <= read_reg(decoded.rs);
            rt_q                <= read_reg(decoded.rt);
            data_req_info.write <= decoded.mem_write;
            data_req_info.addr  <= read_reg(decoded.rs);
            data_req_info.wdata <= read_reg(decoded.rt);
        end
        if (lsu_phase == LSU_REQ && data_ack) begin
            load_q <= data_rdata;
        end
        if (state == gpu_core_pkg::EXECUTE) begin
            alu_q     <= alu_res;
            cmp_nzp_q <= {diff < 0, diff == 0, diff > 0};
        end
        if (state == gpu_core_pkg::UPDATE && enable && decoded.reg_write
                && int'(decoded.rd) < WR_REGS) begin
            regs[decoded.rd] <= wb_val;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            nzp <= '0;
        end else if (state == gpu_core_pkg::UPDATE && enable && decoded.nzp_write) begin
            nzp <= cmp_nzp_q;
        end
    end

    assign next_pc = (decoded.pc_branch && (nzp & decoded.nzp) != '0)
                   ? decoded.imm : pc + gpu_isa_pkg::pc_t'(1);

endmodule

// ==== src/instruction_decoder.sv ====
// Splits the fetched word into fields and control bits, held for the rest of the instruction
`timescale 1ns/1ps

module instruction_decoder (
    input  logic                      clk,
    input  logic                      arst_n,
    input  gpu_core_pkg::core_state_e state,
    input  gpu_isa_pkg::instr_t       instr,
    output gpu_isa_pkg::decoded_t     decoded
);

    gpu_isa_pkg::decoded_t dec_next;

    always_comb begin
        dec_next        = '0;
        dec_next.opcode = gpu_isa_pkg::opcode_e'(instr[15:12]);
        dec_next.rd     = instr[11:8];
        dec_next.rs     = instr[7:4];
        dec_next.rt     = instr[3:0];
        // nzp mask overlaps rd, only BRnzp looks at it
        dec_next.nzp    = instr[11:9];
        dec_next.imm    = instr[7:0];
        case (dec_next.opcode)
            gpu_isa_pkg::ADD, gpu_isa_pkg::SUB, gpu_isa_pkg::MUL, gpu_isa_pkg::CONST: begin
                dec_next.reg_write = 1'b1;
            end
            gpu_isa_pkg::LDR: begin
                dec_next.reg_write = 1'b1;
                dec_next.mem_read  = 1'b1;
            end
            gpu_isa_pkg::STR:   dec_next.mem_write = 1'b1;
            gpu_isa_pkg::CMP:   dec_next.nzp_write = 1'b1;
            gpu_isa_pkg::BRNZP: dec_next.pc_branch = 1'b1;
            gpu_isa_pkg::RET:   dec_next.ret       = 1'b1;
            // NOP and unused codes do nothing
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            decoded <= '0;
        end else if (state == gpu_core_pkg::DECODE) begin
            decoded <= dec_next;
        end
    end

endmodule

// ==== src/instruction_fetcher.sv ====
// Reads one instruction word per FETCH phase over the four-phase program-memory port
`timescale 1ns/1ps

module instruction_fetcher (
    input  logic                      clk,
    input  logic                      arst_n,
    input  gpu_core_pkg::core_state_e state,
    input  gpu_isa_pkg::pc_t          pc,
    output logic                      prog_req,
    output gpu_isa_pkg::pc_t          prog_addr,
    input  logic                      prog_ack,
    input  gpu_isa_pkg::instr_t       prog_data,
    output gpu_isa_pkg::instr_t       instr,
    output logic                      fetch_done
);

    typedef enum logic [1:0] {FET_IDLE, FET_REQ, FET_DROP, FET_DONE} fetch_phase_e;

    fetch_phase_e phase;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= FET_IDLE;
        end else begin
            case (phase)
                // Previous ack must be gone before a new request
                FET_IDLE: if (state == gpu_core_pkg::FETCH && !prog_ack) phase <= FET_REQ;
                FET_REQ:  if (prog_ack) phase <= FET_DROP;
                FET_DROP: if (!prog_ack) phase <= FET_DONE;
                default:  phase <= FET_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == FET_IDLE) begin
            prog_addr <= pc;
        end
        if (phase == FET_REQ && prog_ack) begin
            instr <= prog_data;
        end
    end

    assign prog_req   = (phase == FET_REQ);
    assign fetch_done = (phase == FET_DONE);

    a_addr_stable: assert property (@(posedge clk) disable iff (!arst_n)
        $past(prog_req) && prog_req |-> $stable(prog_addr));

endmodule

// ==== src/lane_completion_counter.sv ====
// Tracks data-memory accesses still outstanding so the scheduler knows when WAIT may end
`timescale 1ns/1ps
`include "gpu_defines.svh"

module lane_completion_counter (
    input  logic                      clk,
    input  logic                      arst_n,
    input  gpu_core_pkg::core_state_e state,
    input  gpu_isa_pkg::decoded_t     decoded,
    input  gpu_core_pkg::thread_cnt_t thread_count,
    input  logic [`GPU_THREADS-1:0]   mem_done,
    output logic                      mem_all_done
);

    gpu_core_pkg::thread_cnt_t pending;
    gpu_core_pkg::thread_cnt_t done_cnt;

    // Lanes finishing this cycle
    always_comb begin
        done_cnt = '0;
        for (int i = 0; i < `GPU_THREADS; i++) begin
            done_cnt = done_cnt + gpu_core_pkg::thread_cnt_t'(mem_done[i]);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= '0;
        end else if (state == gpu_core_pkg::REQUEST) begin
            pending <= (decoded.mem_read || decoded.mem_write) ? thread_count : '0;
        end else begin
            pending <= pending - done_cnt;
        end
    end

    assign mem_all_done = (pending == '0);

    // Lanes never report more completions than were started
    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
        done_cnt <= pending);

endmodule

// ==== src/core_scheduler.sv ====
// Phase sequencer of the core; owns the block PC and answers the kernel start/done handshake
`timescale 1ns/1ps

module core_scheduler (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      start,
    input  logic                      fetch_done,
    input  logic                      mem_all_done,
    input  gpu_isa_pkg::decoded_t     decoded,
    input  gpu_isa_pkg::pc_t          next_pc,
    output gpu_core_pkg::core_state_e state,
    output gpu_isa_pkg::pc_t          pc,
    output logic                      done
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= gpu_core_pkg::IDLE;
            pc    <= '0;
        end else begin
            case (state)
                gpu_core_pkg::IDLE: begin
                    // Every kernel starts at address 0
                    if (start) begin
                        state <= gpu_core_pkg::FETCH;
                        pc    <= '0;
                    end
                end
                gpu_core_pkg::FETCH: begin
                    if (fetch_done) begin
                        state <= gpu_core_pkg::DECODE;
                    end
                end
                gpu_core_pkg::DECODE: begin
                    state <= gpu_core_pkg::REQUEST;
                end
                gpu_core_pkg::REQUEST: begin
                    state <= gpu_core_pkg::WAIT;
                end
                gpu_core_pkg::WAIT: begin
                    // Held here until every lane has finished its access
                    if (mem_all_done) begin
                        state <= gpu_core_pkg::EXECUTE;
                    end
                end
                gpu_core_pkg::EXECUTE: begin
                    state <= gpu_core_pkg::UPDATE;
                end
                gpu_core_pkg::UPDATE: begin
                    pc    <= next_pc;
                    state <= decoded.ret ? gpu_core_pkg::DONE : gpu_core_pkg::FETCH;
                end
                gpu_core_pkg::DONE: begin
                    // Host drops start to close the handshake
                    if (!start) begin
                        state <= gpu_core_pkg::IDLE;
                    end
                end
                default: begin
                    state <= gpu_core_pkg::IDLE;
                end
            endcase
        end
    end

    assign done = (state == gpu_core_pkg::DONE);

    // done must stay up for as long as the host keeps start high
    a_done_held: assert property (@(posedge clk) disable iff (!arst_n)
        (state == gpu_core_pkg::DONE) && start |=> state == gpu_core_pkg::DONE);

endmodule

// ==== src/gpu_core_pkg.sv ====
// Core-control types for the scheduler state and the per-lane data-memory request
`include "gpu_defines.svh"

package gpu_core_pkg;

    // One instruction passes through every phase in order
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        FETCH   = 3'd1,
        DECODE  = 3'd2,
        REQUEST = 3'd3,
        WAIT    = 3'd4,
        EXECUTE = 3'd5,
        UPDATE  = 3'd6,
        DONE    = 3'd7
    } core_state_e;

    // Holds 0 up to the full lane count
    typedef logic [$clog2(`GPU_THREADS):0] thread_cnt_t;

    // Request fields held stable while data_req is high
    typedef struct packed {
        logic                   write;
        logic [`GPU_ADDR_W-1:0] addr;
        logic [`GPU_DATA_W-1:0] wdata;
    } mem_req_t;

endpackage

// ==== src/gpu_isa_pkg.sv ====
// Instruction-set types shared by the decoder, the lanes and the testbench
`include "gpu_defines.svh"

package gpu_isa_pkg;

    typedef logic [`GPU_DATA_W-1:0] word_t;
    typedef logic [`GPU_ADDR_W-1:0] pc_t;
    typedef logic [`GPU_INSTR_W-1:0] instr_t;
    typedef logic [$clog2(`GPU_NUM_REGS)-1:0] reg_idx_t;

    // Opcode lives in instr[15:12]; 4'b0110 is unused
    typedef enum logic [3:0] {
        NOP   = 4'b0000,
        BRNZP = 4'b0001,
        CMP   = 4'b0010,
        ADD   = 4'b0011,
        SUB   = 4'b0100,
        MUL   = 4'b0101,
        LDR   = 4'b0111,
        STR   = 4'b1000,
        CONST = 4'b1001,
        RET   = 4'b1111
    } opcode_e;

    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        logic [2:0] nzp;
        word_t    imm;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     nzp_write;
        logic     pc_branch;
        logic     ret;
    } decoded_t;

endpackage

// ==== include/gpu_defines.svh ====
// Size macros for the SIMT compute core, included by both packages, the RTL and the testbench
`ifndef GPU_DEFINES_SVH
`define GPU_DEFINES_SVH

// Lanes per core, any power of two
`define GPU_THREADS 4

// Register and data-memory word width
`define GPU_DATA_W 8

// Program and data-memory address width
`define GPU_ADDR_W 8

// One instruction word
`define GPU_INSTR_W 16

// Registers per lane; the top three read back block id, thread count and lane id
`define GPU_NUM_REGS 16

`endif
